/* hdl/predictor_defs.svh */
/*
  Width and depth settings for the branch target buffer.
  BTB_INDEX_BITS may range from 2 to 12 and BTB_DEPTH follows from it.
  XLEN is fixed at 32 because the instruction word views assume RV32.
*/

`ifndef PREDICTOR_DEFS_SVH
`define PREDICTOR_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath width
//////////////////////////////////////////////////////////////////////

// Address and data width
`define XLEN 32

//////////////////////////////////////////////////////////////////////
// Table geometry
//////////////////////////////////////////////////////////////////////

// Number of index bits into the target table
`define BTB_INDEX_BITS 6
// Entry count derived from the index width
`define BTB_DEPTH (1 << `BTB_INDEX_BITS)

// PC whose index the table reads while reset is high
`define RESET_VECTOR 32'h0000_1000

`endif

/* hdl/isaPkg.sv */
/*
  RV32 instruction word views, opcode and funct3 encodings, and the
  one-hot control-flow class. Compressed encodings are not covered.
*/

`default_nettype none

package isaPkg;

  // B-type layout with the scattered branch immediate
  typedef struct packed {
    logic       immB12;
    logic [5:0] immB10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] immB4_1;
    logic       immB11;
    logic [6:0] opcode;
  } bView_t;

  // I-type layout
  // The J immediate is rebuilt from immI, rs1 and funct3
  typedef struct packed {
    logic [11:0] immI;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ijView_t;

  typedef union packed {
    logic [31:0] raw;
    bView_t      b;
    ijView_t     ij;
  } instrWord_t;

  // Major opcodes of control-flow instructions
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;

  // Branch conditions
  localparam logic [2:0] BEQ  = 3'b000;
  localparam logic [2:0] BNE  = 3'b001;
  localparam logic [2:0] BLT  = 3'b100;
  localparam logic [2:0] BGE  = 3'b101;
  localparam logic [2:0] BLTU = 3'b110;
  localparam logic [2:0] BGEU = 3'b111;

  // One-hot class, zero means not control flow
  typedef logic [3:0] instrClass_t;

  localparam instrClass_t classNone   = 4'b0000;
  localparam instrClass_t classBranch = 4'b0001;
  localparam instrClass_t classJal    = 4'b0010;
  localparam instrClass_t classJalr   = 4'b0100;
  localparam instrClass_t classReturn = 4'b1000;

endpackage

`default_nettype wire

/* hdl/btbPkg.sv */
/*
  Address, index and entry types of the target table.
  Compile after isaPkg since the entry holds an instruction class.
*/

`default_nettype none

`include "predictor_defs.svh"

package btbPkg;

  // Full-width byte address
  typedef logic [`XLEN-1:0] addr_t;

  // Hashed table index
  typedef logic [`BTB_INDEX_BITS-1:0] btbIndex_t;

  // One table entry
  // Valid bits live beside the array so reset can clear them at once
  typedef struct packed {
    isaPkg::instrClass_t cls;
    addr_t               target;
  } btbEntry_t;

endpackage

`default_nettype wire

/* hdl/instrDecoder.sv */
/*
  Decode stage of the commit path. The instruction word and the
  operands must be stable while accept is high. Words that are not
  BRANCH, JAL or JALR decode to class zero with an immediate of 4.
*/

`timescale 1ns/1ps
`default_nettype none

`include "predictor_defs.svh"

module instrDecoder (
  input  logic                clk,
  input  logic                reset,
  input  logic                accept,
  input  logic [`XLEN-1:0]    instrWord,
  input  btbPkg::addr_t       instrPc,
  input  btbPkg::addr_t       rs1Value,
  input  btbPkg::addr_t       rs2Value,
  output logic                decodeValid,
  output isaPkg::instrClass_t decClass,
  output btbPkg::addr_t       decImm,
  output logic [2:0]          decFunct3,
  output btbPkg::addr_t       decPc,
  output btbPkg::addr_t       decRs1Value,
  output btbPkg::addr_t       decRs2Value
);

  isaPkg::instrWord_t  word;
  isaPkg::instrClass_t classNext;
  btbPkg::addr_t       immNext;

  assign word = instrWord;

  //////////////////////////////////////////////////////////////////////
  // Classification and immediate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    classNext = isaPkg::classNone;
    // Fall-through step so execute always adds pc and imm
    immNext   = `XLEN'(4);
    case (word.b.opcode)
      isaPkg::BRANCH: begin
        classNext = isaPkg::classBranch;
        // Branch offset gathered from the B view
        immNext   = {{(`XLEN-13){word.b.immB12}}, word.b.immB12, word.b.immB11,
                     word.b.immB10_5, word.b.immB4_1, 1'b0};
      end
      isaPkg::JAL: begin
        classNext = isaPkg::classJal;
        // J offset bits 19:12 sit where rs1 and funct3 are
        immNext   = {{(`XLEN-21){word.ij.immI[11]}}, word.ij.immI[11], word.ij.rs1,
                     word.ij.funct3, word.ij.immI[0], word.ij.immI[10:1], 1'b0};
      end
      isaPkg::JALR: begin
        // Return hint is rd x0 with rs1 as ra or t0
        if (word.ij.rd == 5'd0 && (word.ij.rs1 == 5'd1 || word.ij.rs1 == 5'd5))
          classNext = isaPkg::classReturn;
        else
          classNext = isaPkg::classJalr;
        immNext   = {{(`XLEN-12){word.ij.immI[11]}}, word.ij.immI};
      end
      default: ;
    endcase
  end

  // Valid flag follows accept by one cycle
  always_ff @(posedge clk) begin
    if (reset)
      decodeValid <= 1'b0;
    else
      decodeValid <= accept;
  end

  // Captured payload
  always_ff @(posedge clk) begin
    if (accept) begin
      decClass    <= classNext;
      decImm      <= immNext;
      decFunct3   <= word.b.funct3;
      decPc       <= instrPc;
      decRs1Value <= rs1Value;
      decRs2Value <= rs2Value;
    end
  end

  // At most one class bit may come out of the decoder
  assert property (@(posedge clk) disable iff (reset)
    decodeValid |-> $onehot0(decClass));

endmodule

`default_nettype wire

/* hdl/branchExecute.sv */
/*
  Execute stage of the commit path. Targets are computed with a single
  adder over pc or rs1. PCs are assumed 4-byte aligned.
  Results hold until the next decodeValid.
*/

`timescale 1ns/1ps
`default_nettype none

module branchExecute (
  input  logic                clk,
  input  logic                reset,
  input  logic                decodeValid,
  input  isaPkg::instrClass_t decClass,
  input  btbPkg::addr_t       decImm,
  input  logic [2:0]          decFunct3,
  input  btbPkg::addr_t       decPc,
  input  btbPkg::addr_t       decRs1Value,
  input  btbPkg::addr_t       decRs2Value,
  output logic                executeValid,
  output isaPkg::instrClass_t exClass,
  output btbPkg::addr_t       exTarget,
  output logic                exTaken
);

  logic          isIndirect;
  btbPkg::addr_t base;
  btbPkg::addr_t sum;
  btbPkg::addr_t targetNext;
  logic          condMet;
  logic          takenNext;

  // jalr and return add to rs1 and everything else to pc
  assign isIndirect = decClass[2] | decClass[3];
  assign base       = isIndirect ? decRs1Value : decPc;
  assign sum        = base + decImm;
  // Indirect targets drop bit 0
  assign targetNext = isIndirect ? {sum[$bits(sum)-1:1], 1'b0} : sum;

  // Branch condition from funct3
  always_comb begin
    case (decFunct3)
      isaPkg::BEQ:  condMet = decRs1Value == decRs2Value;
      isaPkg::BNE:  condMet = decRs1Value != decRs2Value;
      isaPkg::BLT:  condMet = $signed(decRs1Value) <  $signed(decRs2Value);
      isaPkg::BGE:  condMet = $signed(decRs1Value) >= $signed(decRs2Value);
      isaPkg::BLTU: condMet = decRs1Value <  decRs2Value;
      isaPkg::BGEU: condMet = decRs1Value >= decRs2Value;
      default:      condMet = 1'b0;
    endcase
  end

  // Jumps always go, branches on condition, others never
  assign takenNext = decClass[0] ? condMet : |decClass[3:1];

  always_ff @(posedge clk) begin
    if (reset)
      executeValid <= 1'b0;
    else
      executeValid <= decodeValid;
  end

  always_ff @(posedge clk) begin
    if (decodeValid) begin
      exClass  <= decClass;
      exTarget <= targetNext;
      exTaken  <= takenNext;
    end
  end

  // Direct targets stay even-aligned given aligned PCs and decoded offsets
  assert property (@(posedge clk) disable iff (reset)
    executeValid && exTaken && (exClass[0] || exClass[1]) |-> !exTarget[0]);

endmodule

`default_nettype wire

/* hdl/predictorCommit.sv */
/*
  Result stage and four-phase req/ack responder. One commit is in
  flight at a time. instrPc must stay stable until ack falls because
  the table write happens in the first ack cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module predictorCommit (
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  output logic                ack,
  output logic                accept,
  input  logic                executeValid,
  input  isaPkg::instrClass_t exClass,
  input  btbPkg::addr_t       exTarget,
  input  logic                exTaken,
  input  logic                fetchPredValid,
  input  isaPkg::instrClass_t fetchPredClass,
  input  btbPkg::addr_t       fetchPredTarget,
  output isaPkg::instrClass_t actualClass,
  output btbPkg::addr_t       actualTarget,
  output logic                actualTaken,
  output logic                mispredict,
  output logic                writeEn,
  output isaPkg::instrClass_t writeClass,
  output btbPkg::addr_t       writeTarget,
  output logic                writeValid
);

  localparam logic [1:0] stIdle  = 2'd0;
  localparam logic [1:0] stBusy  = 2'd1;
  localparam logic [1:0] stAcked = 2'd2;

  logic [1:0]          state;
  isaPkg::instrClass_t predClassSeen;
  logic                classWrong;
  logic                mispredictNext;
  logic                needWrite;
  logic                finish;

  // A missing prediction counts as class zero
  assign predClassSeen  = fetchPredValid ? fetchPredClass : isaPkg::classNone;
  assign classWrong     = predClassSeen != exClass;
  assign mispredictNext = classWrong | (exTaken & (exTarget != fetchPredTarget));
  assign needWrite      = |exClass | classWrong;
  assign finish         = (state == stBusy) & executeValid;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= stIdle;
      ack        <= 1'b0;
      accept     <= 1'b0;
      writeEn    <= 1'b0;
      mispredict <= 1'b0;
    end else begin
      accept  <= 1'b0;
      writeEn <= 1'b0;
      case (state)
        // ack is already low here
        stIdle: if (req) begin
          accept <= 1'b1;
          state  <= stBusy;
        end
        stBusy: if (executeValid) begin
          ack        <= 1'b1;
          writeEn    <= needWrite;
          mispredict <= mispredictNext;
          state      <= stAcked;
        end
        // Hold ack until the requester lets go
        stAcked: if (!req) begin
          ack   <= 1'b0;
          state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Result and table write payload
  always_ff @(posedge clk) begin
    if (finish) begin
      actualClass  <= exClass;
      actualTarget <= exTarget;
      actualTaken  <= exTaken;
      writeClass   <= exClass;
      writeTarget  <= exTarget;
      writeValid   <= |exClass;
    end
  end

  // ack rises only for a request still held
  assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req));
  // No new request while the previous one is acknowledged
  assert property (@(posedge clk) disable iff (reset) accept |-> !ack);

endmodule

`default_nettype wire

/* hdl/btbTable.sv */
/*
  Direct-mapped target table with a registered lookup of one cycle.
  Entries carry no tag, so aliasing PCs share an entry.
  A read at the same edge as a write returns the old entry.
*/

`timescale 1ns/1ps
`default_nettype none

`include "predictor_defs.svh"

module btbTable (
  input  logic                clk,
  input  logic                reset,
  input  btbPkg::addr_t       lookupPc,
  input  logic                writeEn,
  input  btbPkg::addr_t       writePc,
  input  isaPkg::instrClass_t writeClass,
  input  btbPkg::addr_t       writeTarget,
  input  logic                writeValid,
  output logic                predValid,
  output isaPkg::instrClass_t predClass,
  output btbPkg::addr_t       predTarget
);

  logic [`BTB_DEPTH-1:0] validBits;
  btbPkg::btbEntry_t     entries [`BTB_DEPTH];
  btbPkg::btbEntry_t     readEntry;
  btbPkg::btbIndex_t     readIndex;
  btbPkg::btbIndex_t     writeIndex;

  //////////////////////////////////////////////////////////////////////
  // Index hash
  //////////////////////////////////////////////////////////////////////

  // Bit 0 is always zero and bit 1 is folded into the top index bit
  function automatic btbPkg::btbIndex_t hashPc(input btbPkg::addr_t pc);
    return {pc[`BTB_INDEX_BITS+1] ^ pc[1], pc[`BTB_INDEX_BITS:2]};
  endfunction

  // Reset gives a defined read index while fetch PC is not yet valid
  assign readIndex  = reset ? hashPc(`RESET_VECTOR) : hashPc(lookupPc);
  assign writeIndex = hashPc(writePc);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Valid bit tracks whether the stored class is control flow
  always_ff @(posedge clk) begin
    if (reset)
      validBits <= '0;
    else if (writeEn)
      validBits[writeIndex] <= writeValid;
  end

  always_ff @(posedge clk) begin
    if (writeEn)
      entries[writeIndex] <= '{cls: writeClass, target: writeTarget};
  end

  // Registered lookup
  always_ff @(posedge clk) begin
    if (reset)
      predValid <= 1'b0;
    else
      predValid <= validBits[readIndex];
  end

  always_ff @(posedge clk) begin
    readEntry <= entries[readIndex];
  end

  assign predClass  = readEntry.cls;
  assign predTarget = readEntry.target;

  // Only decoded classes ever reach a valid entry
  assert property (@(posedge clk) disable iff (reset)
    predValid |-> $onehot0(predClass));

endmodule

`default_nettype wire

/* hdl/branchPredictorTop.sv */
/*
  Branch target buffer with its commit path. Lookup results follow
  lookupPc by one cycle. Commits use a four-phase req/ack handshake
  and all commit inputs stay stable from req rising to ack falling.
*/

`timescale 1ns/1ps
`default_nettype none

`include "predictor_defs.svh"

module branchPredictorTop (
  input  logic                clk,
  input  logic                reset,
  // Lookup side
  input  btbPkg::addr_t       lookupPc,
  output logic                predValid,
  output isaPkg::instrClass_t predClass,
  output btbPkg::addr_t       predTarget,
  // Commit side
  input  logic                req,
  output logic                ack,
  input  btbPkg::addr_t       instrPc,
  input  logic [`XLEN-1:0]    instrWord,
  input  btbPkg::addr_t       rs1Value,
  input  btbPkg::addr_t       rs2Value,
  input  logic                fetchPredValid,
  input  isaPkg::instrClass_t fetchPredClass,
  input  btbPkg::addr_t       fetchPredTarget,
  output isaPkg::instrClass_t actualClass,
  output btbPkg::addr_t       actualTarget,
  output logic                actualTaken,
  output logic                mispredict
);

  logic                accept;
  logic                decodeValid;
  isaPkg::instrClass_t decClass;
  btbPkg::addr_t       decImm;
  logic [2:0]          decFunct3;
  btbPkg::addr_t       decPc;
  btbPkg::addr_t       decRs1Value;
  btbPkg::addr_t       decRs2Value;
  logic                executeValid;
  isaPkg::instrClass_t exClass;
  btbPkg::addr_t       exTarget;
  logic                exTaken;
  logic                writeEn;
  isaPkg::instrClass_t writeClass;
  btbPkg::addr_t       writeTarget;
  logic                writeValid;

  instrDecoder decode_i (
    .clk, .reset, .accept, .instrWord, .instrPc, .rs1Value, .rs2Value,
    .decodeValid, .decClass, .decImm, .decFunct3, .decPc, .decRs1Value, .decRs2Value
  );

  branchExecute execute_i (
    .clk, .reset, .decodeValid, .decClass, .decImm, .decFunct3, .decPc,
    .decRs1Value, .decRs2Value, .executeValid, .exClass, .exTarget, .exTaken
  );

  // Result stage also paces the pipeline through accept
  predictorCommit commit_i (
    .clk, .reset, .req, .ack, .accept, .executeValid, .exClass, .exTarget, .exTaken,
    .fetchPredValid, .fetchPredClass, .fetchPredTarget,
    .actualClass, .actualTarget, .actualTaken, .mispredict,
    .writeEn, .writeClass, .writeTarget, .writeValid
  );

  // Write index comes straight from the held commit PC
  btbTable table_i (
    .clk, .reset, .lookupPc, .writeEn, .writePc(instrPc), .writeClass, .writeTarget,
    .writeValid, .predValid, .predClass, .predTarget
  );

endmodule

`default_nettype wire

/* verification/tbBranchPredictor.sv */
/*
  Self-checking testbench for the branch target buffer.
  Records come from verification/btb_patterns.txt, run from the project root.
  A local table model supplies the fetch prediction and the expected lookups.
  The run stops at the first wrong value.
*/

`timescale 1ns/1ps
`default_nettype none

`include "predictor_defs.svh"

module tbBranchPredictor;

  logic                clk;
  logic                reset;
  btbPkg::addr_t       lookupPc;
  logic                predValid;
  isaPkg::instrClass_t predClass;
  btbPkg::addr_t       predTarget;
  logic                req;
  logic                ack;
  btbPkg::addr_t       instrPc;
  logic [`XLEN-1:0]    instrWord;
  btbPkg::addr_t       rs1Value;
  btbPkg::addr_t       rs2Value;
  logic                fetchPredValid;
  isaPkg::instrClass_t fetchPredClass;
  btbPkg::addr_t       fetchPredTarget;
  isaPkg::instrClass_t actualClass;
  btbPkg::addr_t       actualTarget;
  logic                actualTaken;
  logic                mispredict;

  // Pattern records, one entry per file line
  btbPkg::addr_t       patPc [$];
  logic [`XLEN-1:0]    patWord [$];
  btbPkg::addr_t       patRs1 [$];
  btbPkg::addr_t       patRs2 [$];
  isaPkg::instrClass_t patClass [$];
  btbPkg::addr_t       patTarget [$];
  logic                patTaken [$];
  int                  recordCount = 0;
  logic                loaded = 1'b0;
  logic [31:0]         rngState;

  // Reference table model
  logic                modelValid [`BTB_DEPTH];
  isaPkg::instrClass_t modelClass [`BTB_DEPTH];
  btbPkg::addr_t       modelTarget [`BTB_DEPTH];

  branchPredictorTop dut_i (
    .clk, .reset, .lookupPc, .predValid, .predClass, .predTarget,
    .req, .ack, .instrPc, .instrWord, .rs1Value, .rs2Value,
    .fetchPredValid, .fetchPredClass, .fetchPredTarget,
    .actualClass, .actualTarget, .actualTaken, .mispredict
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkClass(input string what, input isaPkg::instrClass_t got,
                            input isaPkg::instrClass_t exp);
    if (got !== exp)
      failRun($sformatf("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkAddr(input string what, input btbPkg::addr_t got,
                           input btbPkg::addr_t exp);
    if (got !== exp)
      failRun($sformatf("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model helpers
  //////////////////////////////////////////////////////////////////////

  // Word index from PC bits above 1, then bit 1 flips the top index bit
  function automatic int unsigned hashIndex(input btbPkg::addr_t pc);
    int unsigned idx;
    idx = (pc >> 2) & ((1 << `BTB_INDEX_BITS) - 1);
    if (pc[1])
      idx = idx ^ (1 << (`BTB_INDEX_BITS - 1));
    return idx;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  // Random PCs near the pattern PCs, bit 1 included so aliases show up
  function automatic btbPkg::addr_t randomPc();
    return `RESET_VECTOR | ((nextRandom() >> 16) & 32'h0000_00fe);
  endfunction

  task automatic readPatterns();
    int                  fd;
    int                  code;
    int                  fields;
    logic [8*160-1:0]    lineBuf;
    btbPkg::addr_t       pc;
    logic [`XLEN-1:0]    word;
    btbPkg::addr_t       rs1;
    btbPkg::addr_t       rs2;
    isaPkg::instrClass_t cls;
    btbPkg::addr_t       tgt;
    logic                taken;
    fd = $fopen("verification/btb_patterns.txt", "r");
    if (fd == 0)
      failRun("could not open the pattern file verification/btb_patterns.txt");
    while (!$feof(fd)) begin
      lineBuf = '0;
      code = $fgets(lineBuf, fd);
      if (code == 0)
        break;
      // Comment and blank lines scan no field
      fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h", pc, word, rs1, rs2, cls, tgt, taken);
      if (fields == 7) begin
        patPc.push_back(pc);
        patWord.push_back(word);
        patRs1.push_back(rs1);
        patRs2.push_back(rs2);
        patClass.push_back(cls);
        patTarget.push_back(tgt);
        patTaken.push_back(taken);
      end else if (fields > 0) begin
        failRun("pattern file has a record with missing fields");
      end
    end
    $fclose(fd);
    recordCount = patPc.size();
    if (recordCount == 0)
      failRun("pattern file holds no records");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Port drivers, entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  // One-cycle registered lookup checked against the model
  task automatic compareLookup(input btbPkg::addr_t pc);
    int unsigned idx;
    idx = hashIndex(pc);
    lookupPc = pc;
    @(posedge clk);
    @(negedge clk);
    checkFlag("predValid", predValid, modelValid[idx]);
    if (modelValid[idx]) begin
      checkClass("predClass", predClass, modelClass[idx]);
      checkAddr("predTarget", predTarget, modelTarget[idx]);
    end
  endtask

  // Full four-phase commit of one record
  task automatic commitRecord(input int n, input bit lateDrop);
    int unsigned         idx;
    int                  edges;
    isaPkg::instrClass_t seenClass;
    logic                expMispredict;
    idx = hashIndex(patPc[n]);
    checkFlag("ack before req", ack, 1'b0);
    instrPc         = patPc[n];
    instrWord       = patWord[n];
    rs1Value        = patRs1[n];
    rs2Value        = patRs2[n];
    fetchPredValid  = modelValid[idx];
    fetchPredClass  = modelClass[idx];
    fetchPredTarget = modelTarget[idx];
    req             = 1'b1;
    // The edge that samples req is not counted
    edges = -1;
    while (ack !== 1'b1) begin
      @(posedge clk);
      @(negedge clk);
      edges++;
      if (edges > 10)
        failRun("ack did not rise within 10 cycles of req");
    end
    if (edges != 3)
      failRun($sformatf("MISMATCH at time %0t: ack rose %0d edges after req, expected 3",
                        $time, edges));
    // Expected mispredict from the prediction that fetch handed in
    seenClass     = modelValid[idx] ? modelClass[idx] : isaPkg::classNone;
    expMispredict = (seenClass != patClass[n]) ||
                    (patTaken[n] && (patTarget[n] != modelTarget[idx]));
    checkClass("actualClass", actualClass, patClass[n]);
    checkAddr("actualTarget", actualTarget, patTarget[n]);
    checkFlag("actualTaken", actualTaken, patTaken[n]);
    checkFlag("mispredict", mispredict, expMispredict);
    // Slow requester, ack must wait for req to fall
    if (lateDrop) begin
      repeat (2) begin
        @(posedge clk);
        @(negedge clk);
        checkFlag("ack while req held", ack, 1'b1);
      end
    end
    req = 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkFlag("ack one cycle after req fell", ack, 1'b0);
    // Table update rule
    if (patClass[n] != isaPkg::classNone || seenClass != patClass[n]) begin
      modelValid[idx]  = (patClass[n] != isaPkg::classNone);
      modelClass[idx]  = patClass[n];
      modelTarget[idx] = patTarget[n];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    lookupPc        = `RESET_VECTOR;
    req             = 1'b0;
    instrPc         = '0;
    instrWord       = '0;
    rs1Value        = '0;
    rs2Value        = '0;
    fetchPredValid  = 1'b0;
    fetchPredClass  = isaPkg::classNone;
    fetchPredTarget = '0;
    rngState        = 32'hcb23_ffb6;
    for (int i = 0; i < `BTB_DEPTH; i++) begin
      modelValid[i]  = 1'b0;
      modelClass[i]  = isaPkg::classNone;
      modelTarget[i] = '0;
    end
    readPatterns();
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    // Empty table right after reset
    repeat (4) compareLookup(randomPc());
    for (int n = 0; n < recordCount; n++) begin
      commitRecord(n, (n % 3) == 0);
      compareLookup(patPc[n]);
      compareLookup(randomPc());
    end
    // Aliasing sweep over the filled table
    repeat (32) compareLookup(randomPc());
    $display("Testbench passed");
    $finish;
  end

  // Budget of 12 cycles per record plus 200 spare cycles
  initial begin
    wait (loaded === 1'b1);
    #((recordCount * 12 + 200) * 20);
    failRun($sformatf("watchdog expired, run exceeded its budget for %0d records",
                      recordCount));
  end

endmodule

`default_nettype wire

/* verification/btb_patterns.txt */
# instrPc instrWord rs1Value rs2Value class target taken, all fields in hex
# class is one-hot: 1 branch, 2 jal, 4 jalr, 8 return, 0 not control flow
00001004 00b50863 00000005 00000005 1 00001014 1
00001008 00b51863 00000005 00000005 1 00001018 0
0000100c 00b54863 ffffffff 00000001 1 0000101c 1
00001010 00b55863 ffffffff 00000001 1 00001020 0
00001014 00b56863 ffffffff 00000001 1 00001024 0
00001018 00b57863 ffffffff 00000001 1 00001028 1
00001040 feb51ce3 00000003 00000004 1 00001038 1
00001050 040000ef 00000000 00000000 2 00001090 1
00001060 fe1ff06f 00000000 00000000 2 00001040 1
00001070 008300e7 00002001 00000000 4 00002008 1
00001080 00008067 00001234 00000000 8 00001234 1
00001084 00028067 00001100 00000000 8 00001100 1
00001088 00000013 00000000 00000000 0 0000108c 0
00001004 00b50863 00000005 00000005 1 00001014 1
00001050 040000ef 00000000 00000000 2 00001090 1
00001070 008300e7 00003000 00000000 4 00003008 1
00001086 00000013 00000000 00000000 0 0000108a 0
00001004 00b50863 00000005 00000005 1 00001014 1
00001090 00030067 00004003 00000000 4 00004002 1

/* all.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/btbPkg.sv
hdl/instrDecoder.sv
hdl/branchExecute.sv
hdl/predictorCommit.sv
hdl/btbTable.sv
hdl/branchPredictorTop.sv
verification/tbBranchPredictor.sv

/* Bender.yml */
package:
  name: branch_predictor

export_include_dirs:
  - hdl

sources:
  - hdl/isaPkg.sv
  - hdl/btbPkg.sv
  - hdl/instrDecoder.sv
  - hdl/branchExecute.sv
  - hdl/predictorCommit.sv
  - hdl/btbTable.sv
  - hdl/branchPredictorTop.sv
  - target: simulation
    files:
      - verification/tbBranchPredictor.sv
